/* cdb.sv */
// Common data bus, arbitration between units and the result multiplexer
`timescale 1ns/1ps
`default_nettype none

module cdb (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic                        flush_i,

    // Maximum-priority unit
    input  logic                        max_prio_valid_i,
    output logic                        max_prio_ready_o,
    input  expipe_pkg::cdb_data_t       max_prio_data_i,

    // Low-priority units, entry i is unit i+1
    input  logic [expipe_pkg::EU_N-2:0] rs_valid_i,
    output logic [expipe_pkg::EU_N-2:0] rs_ready_o,
    input  expipe_pkg::cdb_data_t       rs_data_i [expipe_pkg::EU_N-1],

    // To the ROB and the issue queue
    input  logic                        rob_ready_i,
    output logic                        rob_valid_o,
    output expipe_pkg::cdb_data_t       rob_data_o
);

    import expipe_pkg::*;

    logic                  served_max_prio;
    logic [EU_IDX_LEN-1:0] served;
    logic [EU_IDX_LEN-1:0] rs_sel;

    // --------------------------------------------------
    // Arbiter
    // --------------------------------------------------
    cdb_arbiter u_cdb_arbiter (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .max_prio_valid_i  (max_prio_valid_i),
        .max_prio_ready_o  (max_prio_ready_o),
        .valid_i           (rs_valid_i),
        .ready_o           (rs_ready_o),
        .rob_ready_i       (rob_ready_i),
        .rob_valid_o       (rob_valid_o),
        .served_max_prio_o (served_max_prio),
        .served_o          (served)
    );

    // --------------------------------------------------
    // Result multiplexer
    // --------------------------------------------------
    // Served is a unit number, the array starts at unit 1
    assign rs_sel = served - 1'b1;

    assign rob_data_o = served_max_prio ? max_prio_data_i : rs_data_i[rs_sel];

endmodule

`default_nettype wire

/* cdb_arbiter.sv */
// CDB arbiter, fixed winner for unit 0 and round-robin among the other units
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    // Maximum-priority unit
    input  logic                             max_prio_valid_i,
    output logic                             max_prio_ready_o,

    // Low-priority units, bit i is unit i+1
    input  logic [expipe_pkg::EU_N-2:0]      valid_i,
    output logic [expipe_pkg::EU_N-2:0]      ready_o,

    // ROB side
    input  logic                             rob_ready_i,
    output logic                             rob_valid_o,

    // Winner of this cycle
    output logic                             served_max_prio_o,
    output logic [expipe_pkg::EU_IDX_LEN-1:0] served_o
);

    import expipe_pkg::*;

    // Unit number where the search starts, 1 to EU_N-1
    logic [EU_IDX_LEN-1:0] rr_ptr;
    logic [EU_IDX_LEN-1:0] rr_winner;
    logic                  rr_found;
    logic                  rr_xfer;
    int                    rr_cand;

    // --------------------------------------------------
    // Round-robin search
    // --------------------------------------------------
    // First valid unit at or after the pointer, wrapping
    always_comb begin
        rr_found  = 1'b0;
        rr_winner = rr_ptr;
        rr_cand   = 0;
        for (int k = 0; k < int'(EU_N - 1); k++) begin
            rr_cand = (int'(rr_ptr) - 1 + k) % int'(EU_N - 1);
            if (!rr_found && valid_i[rr_cand]) begin
                rr_found  = 1'b1;
                rr_winner = EU_IDX_LEN'(rr_cand + 1);
            end
        end
    end

    // Unit 0 overrides the round-robin choice
    assign served_max_prio_o = max_prio_valid_i;
    assign served_o          = rr_winner;
    assign rob_valid_o       = max_prio_valid_i | rr_found;

    // Grants, only the winner and only if the ROB takes it
    assign max_prio_ready_o = max_prio_valid_i & rob_ready_i;
    assign rr_xfer          = rr_found & ~max_prio_valid_i & rob_ready_i;

    always_comb begin
        ready_o = '0;
        if (rr_xfer) begin
            ready_o[rr_winner - 1'b1] = 1'b1;
        end
    end

    // --------------------------------------------------
    // Pointer update
    // --------------------------------------------------
    // Moves past the winner on a low-priority transfer
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            rr_ptr <= EU_IDX_LEN'(1);
        end else if (rr_xfer) begin
            if (rr_winner == EU_IDX_LEN'(EU_N - 1)) begin
                rr_ptr <= EU_IDX_LEN'(1);
            end else begin
                rr_ptr <= rr_winner + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* cdb_subsys.sv */
// Write-back subsystem, result buffers feeding the CDB and the reorder buffer
`timescale 1ns/1ps
`default_nettype none

module cdb_subsys (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,

    // Execution units, unit 0 has maximum priority
    input  logic [expipe_pkg::EU_N-1:0]      eu_valid_i,
    output logic [expipe_pkg::EU_N-1:0]      eu_ready_o,
    input  expipe_pkg::cdb_data_t            eu_data_i [expipe_pkg::EU_N],

    // Broadcast to the issue queue
    output logic                             cdb_valid_o,
    output expipe_pkg::cdb_data_t            cdb_data_o,

    // Allocation
    input  logic                             alloc_valid_i,
    output logic                             alloc_ready_o,
    output logic [len5_pkg::ROB_IDX_LEN-1:0] alloc_idx_o,

    // Commit
    output logic                             commit_valid_o,
    input  logic                             commit_ready_i,
    output expipe_pkg::commit_data_t         commit_data_o
);

    import expipe_pkg::*;

    // Buffer 0 to the maximum-priority port
    logic            mp_valid;
    logic            mp_ready;
    cdb_data_t       mp_data;

    // Buffers 1 to EU_N-1, entry i is buffer i+1
    logic [EU_N-2:0] rs_valid;
    logic [EU_N-2:0] rs_ready;
    cdb_data_t       rs_data [EU_N-1];

    // CDB to ROB
    logic            rob_valid;
    logic            rob_ready;
    cdb_data_t       rob_data;

    // --------------------------------------------------
    // Result buffers
    // --------------------------------------------------
    for (genvar i = 0; i < EU_N; i++) begin : g_res_buf
        if (i == 0) begin : g_max_prio
            eu_result_buffer u_res_buf (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .flush_i     (flush_i),
                .eu_valid_i  (eu_valid_i[i]),
                .eu_ready_o  (eu_ready_o[i]),
                .eu_data_i   (eu_data_i[i]),
                .cdb_valid_o (mp_valid),
                .cdb_ready_i (mp_ready),
                .cdb_data_o  (mp_data)
            );
        end else begin : g_low_prio
            eu_result_buffer u_res_buf (
                .clk_i       (clk_i),
                .rst_n_i     (rst_n_i),
                .flush_i     (flush_i),
                .eu_valid_i  (eu_valid_i[i]),
                .eu_ready_o  (eu_ready_o[i]),
                .eu_data_i   (eu_data_i[i]),
                .cdb_valid_o (rs_valid[i-1]),
                .cdb_ready_i (rs_ready[i-1]),
                .cdb_data_o  (rs_data[i-1])
            );
        end
    end

    // --------------------------------------------------
    // Bus and reorder buffer
    // --------------------------------------------------
    cdb u_cdb (
        .clk_i            (clk_i),
        .rst_n_i          (rst_n_i),
        .flush_i          (flush_i),
        .max_prio_valid_i (mp_valid),
        .max_prio_ready_o (mp_ready),
        .max_prio_data_i  (mp_data),
        .rs_valid_i       (rs_valid),
        .rs_ready_o       (rs_ready),
        .rs_data_i        (rs_data),
        .rob_ready_i      (rob_ready),
        .rob_valid_o      (rob_valid),
        .rob_data_o       (rob_data)
    );

    rob u_rob (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .alloc_valid_i  (alloc_valid_i),
        .alloc_ready_o  (alloc_ready_o),
        .alloc_idx_o    (alloc_idx_o),
        .cdb_valid_i    (rob_valid),
        .cdb_ready_o    (rob_ready),
        .cdb_data_i     (rob_data),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_data_o  (commit_data_o)
    );

    // Issue queue sees the bus as the ROB does
    assign cdb_valid_o = rob_valid;
    assign cdb_data_o  = rob_data;

endmodule

`default_nettype wire

/* cdb_subsys_assert.sv */
// Bound checks on the CDB, result buffer and commit handshakes of the subsystem
`timescale 1ns/1ps
`default_nettype none

module cdb_subsys_assert (
    input logic                            clk_i,
    input logic                            rst_n_i,
    input logic                            flush_i,
    input logic [expipe_pkg::EU_N-1:0]     eu_valid_i,
    input logic [expipe_pkg::EU_N-1:0]     eu_ready_i,
    input logic                            mp_valid_i,
    input logic                            mp_ready_i,
    input logic [expipe_pkg::EU_N-2:0]     rs_valid_i,
    input logic [expipe_pkg::EU_N-2:0]     rs_ready_i,
    input logic                            cdb_valid_i,
    input logic                            commit_valid_i,
    input logic                            commit_ready_i,
    input expipe_pkg::commit_data_t        commit_data_i
);

    import expipe_pkg::*;

    // Unit results held until the buffer takes them
    for (genvar i = 0; i < EU_N; i++) begin : g_eu_hold
        a_eu_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
            eu_valid_i[i] && !eu_ready_i[i] |=> eu_valid_i[i])
            else $error("unit result dropped before acceptance");
    end

    // Unserved bus sources keep their valid
    a_mp_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        mp_valid_i && !mp_ready_i |=> mp_valid_i)
        else $error("maximum-priority source dropped valid");

    for (genvar i = 0; i < EU_N - 1; i++) begin : g_rs_hold
        a_rs_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
            rs_valid_i[i] && !rs_ready_i[i] |=> rs_valid_i[i])
            else $error("low-priority source dropped valid");
    end

    a_commit_hold : assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        commit_valid_i && !commit_ready_i |=> commit_valid_i && $stable(commit_data_i))
        else $error("stalled commit changed");

    // One grant per cycle at most
    a_one_grant : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0({mp_ready_i, rs_ready_i}))
        else $error("more than one CDB source granted");

    a_quiet_after_clear : assert property (@(posedge clk_i)
        (!rst_n_i || flush_i) |=> !commit_valid_i && !cdb_valid_i)
        else $error("valid output high after reset or flush");

endmodule

bind cdb_subsys cdb_subsys_assert i_cdb_subsys_assert (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .flush_i        (flush_i),
    .eu_valid_i     (eu_valid_i),
    .eu_ready_i     (eu_ready_o),
    .mp_valid_i     (mp_valid),
    .mp_ready_i     (mp_ready),
    .rs_valid_i     (rs_valid),
    .rs_ready_i     (rs_ready),
    .cdb_valid_i    (cdb_valid_o),
    .commit_valid_i (commit_valid_o),
    .commit_ready_i (commit_ready_i),
    .commit_data_i  (commit_data_o)
);

`default_nettype wire

/* eu_result_buffer.sv */
// Small FIFO that holds one execution unit's results until the CDB serves them
`timescale 1ns/1ps
`default_nettype none

module eu_result_buffer (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // From the execution unit
    input  logic                  eu_valid_i,
    output logic                  eu_ready_o,
    input  expipe_pkg::cdb_data_t eu_data_i,

    // To the CDB
    output logic                  cdb_valid_o,
    input  logic                  cdb_ready_i,
    output expipe_pkg::cdb_data_t cdb_data_o
);

    import expipe_pkg::*;

    localparam int unsigned PTR_LEN = (RES_BUF_DEPTH > 1) ? $clog2(RES_BUF_DEPTH) : 1;
    localparam int unsigned CNT_LEN = $clog2(RES_BUF_DEPTH + 1);

    // Storage and pointers
    cdb_data_t          buf_mem [RES_BUF_DEPTH];
    logic [PTR_LEN-1:0] rd_ptr;
    logic [PTR_LEN-1:0] wr_ptr;
    logic [CNT_LEN-1:0] count;

    logic push;
    logic pop;

    // Handshakes
    assign eu_ready_o  = (count != CNT_LEN'(RES_BUF_DEPTH));
    assign cdb_valid_o = (count != '0);
    assign push        = eu_valid_i & eu_ready_o;
    assign pop         = cdb_valid_o & cdb_ready_i;

    // Oldest entry always on the output
    assign cdb_data_o = buf_mem[rd_ptr];

    // --------------------------------------------------
    // Pointers and occupancy
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_LEN'(RES_BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_LEN'(RES_BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Push and pop together leave the count as is
            count <= count + CNT_LEN'(push) - CNT_LEN'(pop);
        end
    end

    // Payload only
    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_mem[wr_ptr] <= eu_data_i;
        end
    end

endmodule

`default_nettype wire

/* expipe_pkg.sv */
// Execution pipeline constants and the CDB and commit data types
`default_nettype none

package expipe_pkg;

    import len5_pkg::*;

    // --------------------------------------------------
    // Units on the CDB
    // --------------------------------------------------
    // Unit 0 has maximum priority, units 1 to EU_N-1 share round-robin
    localparam int unsigned EU_N = 4;
    // Width of a unit number, holds 0 to EU_N-1
    localparam int unsigned EU_IDX_LEN = $clog2(EU_N);
    // Entries in each result buffer
    localparam int unsigned RES_BUF_DEPTH = 2;

    // --------------------------------------------------
    // CDB value word
    // --------------------------------------------------
    // Exception view, cause in the low bits
    typedef struct packed {
        logic [XLEN-EXCEPT_LEN-1:0] pad;    // Zero from the producing unit
        except_code_t               cause;
    } cdb_except_view_t;

    // Same word, read by except_raised
    typedef union packed {
        logic [XLEN-1:0]  result;
        cdb_except_view_t except;
    } cdb_value_u;

    // --------------------------------------------------
    // Bus and commit payloads
    // --------------------------------------------------
    // One result on the CDB
    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] rob_idx;
        cdb_value_u             value;
        logic                   except_raised;
    } cdb_data_t;

    // Head entry leaving the ROB
    typedef struct packed {
        logic [ROB_IDX_LEN-1:0] rob_idx;
        cdb_value_u             value;
        logic                   except_raised;
    } commit_data_t;

endpackage

`default_nettype wire

/* len5_pkg.sv */
// Core-wide word widths, ROB sizing and the exception cause type
`default_nettype none

package len5_pkg;

    // --------------------------------------------------
    // Data path
    // --------------------------------------------------
    // Integer register and data word width
    localparam int unsigned XLEN = 32;

    // --------------------------------------------------
    // Reorder buffer sizing
    // --------------------------------------------------
    // Number of in-flight instructions
    localparam int unsigned ROB_DEPTH = 8;
    // Index width, log2 of ROB_DEPTH
    localparam int unsigned ROB_IDX_LEN = 3;

    // --------------------------------------------------
    // Exceptions
    // --------------------------------------------------
    // Width of the RISC-V exception cause field
    localparam int unsigned EXCEPT_LEN = 5;

    // Cause code as carried on the CDB and at commit
    typedef logic [EXCEPT_LEN-1:0] except_code_t;

endpackage

`default_nettype wire

/* list.f */
len5_pkg.sv
expipe_pkg.sv
eu_result_buffer.sv
cdb_arbiter.sv
cdb.sv
rob.sv
cdb_subsys.sv
cdb_subsys_assert.sv
tb_cdb_subsys.sv

/* rob.sv */
// Reorder buffer, in-order allocation, out-of-order completion, in-order commit
`timescale 1ns/1ps
`default_nettype none

module rob (
    input  logic                               clk_i,
    input  logic                               rst_n_i,
    input  logic                               flush_i,

    // Allocation from the issue stage
    input  logic                               alloc_valid_i,
    output logic                               alloc_ready_o,
    output logic [len5_pkg::ROB_IDX_LEN-1:0]   alloc_idx_o,

    // Write-back from the CDB
    input  logic                               cdb_valid_i,
    output logic                               cdb_ready_o,
    input  expipe_pkg::cdb_data_t              cdb_data_i,

    // Commit of the head entry
    output logic                               commit_valid_o,
    input  logic                               commit_ready_i,
    output expipe_pkg::commit_data_t           commit_data_o
);

    import len5_pkg::*;
    import expipe_pkg::*;

    // --------------------------------------------------
    // State
    // --------------------------------------------------
    // Per-entry control bits
    logic [ROB_DEPTH-1:0]   busy;
    logic [ROB_DEPTH-1:0]   done;

    // Result store, one port shared by commit and write-back
    cdb_value_u             value_mem [ROB_DEPTH];
    logic                   except_mem [ROB_DEPTH];

    // Pointers wrap by overflow, depth is a power of two
    logic [ROB_IDX_LEN-1:0] head;
    logic [ROB_IDX_LEN-1:0] tail;
    logic [ROB_IDX_LEN:0]   count;

    logic alloc_xfer;
    logic wb_xfer;
    logic commit_xfer;

    // --------------------------------------------------
    // Handshakes
    // --------------------------------------------------
    assign alloc_ready_o  = (count != (ROB_IDX_LEN+1)'(ROB_DEPTH));
    assign alloc_idx_o    = tail;
    assign commit_valid_o = busy[head] & done[head];
    assign commit_xfer    = commit_valid_o & commit_ready_i;
    // Store port belongs to commit in a commit cycle
    assign cdb_ready_o    = ~commit_xfer;

    assign alloc_xfer = alloc_valid_i & alloc_ready_o;
    assign wb_xfer    = cdb_valid_i & cdb_ready_o;

    // Head entry straight out
    assign commit_data_o.rob_idx       = head;
    assign commit_data_o.value         = value_mem[head];
    assign commit_data_o.except_raised = except_mem[head];

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            busy  <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            // Completion in any order, only for live entries
            if (wb_xfer && busy[cdb_data_i.rob_idx]) begin
                done[cdb_data_i.rob_idx] <= 1'b1;
            end
            // Retire the head
            if (commit_xfer) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            // New entry at the tail, not done yet
            if (alloc_xfer) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            count <= count + (ROB_IDX_LEN+1)'(alloc_xfer) - (ROB_IDX_LEN+1)'(commit_xfer);
        end
    end

    // --------------------------------------------------
    // Result store
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (wb_xfer) begin
            value_mem[cdb_data_i.rob_idx]  <= cdb_data_i.value;
            except_mem[cdb_data_i.rob_idx] <= cdb_data_i.except_raised;
        end
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the CDB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_cdb_subsys -f list.f

# An assertion stop ends the run early, the log decides
./obj_dir/Vtb_cdb_subsys > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "Result: failing run, see $LOG"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "Result: run ended without a verdict, see $LOG"
    exit 1
fi
echo "Result: run passed"

/* tb_cdb_subsys.sv */
// Directed testbench for the CDB write-back subsystem with a reference ROB model
`timescale 1ns/1ps
`default_nettype none

module tb_cdb_subsys;

    import len5_pkg::*;
    import expipe_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 5;
    localparam int MAX_WAIT     = 40;
    // Cycle budget of the tests in running order
    localparam int TEST_CYCLES  = RESET_CYCLES + 30 + 30 + 20 + 60 + 25;
    localparam int WATCHDOG_NS  = TEST_CYCLES * 2 * CLK_PERIOD;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   flush_i;
    logic [EU_N-1:0]        eu_valid_i;
    logic [EU_N-1:0]        eu_ready_o;
    cdb_data_t              eu_data_i [EU_N];
    logic                   cdb_valid_o;
    cdb_data_t              cdb_data_o;
    logic                   alloc_valid_i;
    logic                   alloc_ready_o;
    logic [ROB_IDX_LEN-1:0] alloc_idx_o;
    logic                   commit_valid_o;
    logic                   commit_ready_i;
    commit_data_t           commit_data_o;

    // Reference ROB indices in allocation order
    logic [ROB_IDX_LEN-1:0] order_q [$];
    logic [ROB_IDX_LEN-1:0] tail_model;
    cdb_value_u             exp_value [ROB_DEPTH];
    logic                   exp_except [ROB_DEPTH];
    // Expected round-robin pointer as a unit number
    int                     rr_model;

    // Observed traffic
    commit_data_t           commit_q [$];
    cdb_data_t              bcast_q [$];
    int                     stall_cnt [EU_N];

    logic [31:0]            lcg_state;
    int                     err_cnt;
    int                     chk_cnt;

    cdb_subsys i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .eu_valid_i     (eu_valid_i),
        .eu_ready_o     (eu_ready_o),
        .eu_data_i      (eu_data_i),
        .cdb_valid_o    (cdb_valid_o),
        .cdb_data_o     (cdb_data_o),
        .alloc_valid_i  (alloc_valid_i),
        .alloc_ready_o  (alloc_ready_o),
        .alloc_idx_o    (alloc_idx_o),
        .commit_valid_o (commit_valid_o),
        .commit_ready_i (commit_ready_i),
        .commit_data_o  (commit_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    // --------------------------------------------------
    // Monitor sampling mid-cycle once all has settled
    // --------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_n_i && !flush_i) begin
            if (commit_valid_o && commit_ready_i) begin
                commit_q.push_back(commit_data_o);
            end
            // Bus waits while a commit owns the ROB store
            if (cdb_valid_o && !(commit_valid_o && commit_ready_i)) begin
                bcast_q.push_back(cdb_data_o);
            end
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Pointer moves to the unit after the winner and wraps to unit 1
    function automatic int next_rr(input int unit);
        return (unit == EU_N - 1) ? 1 : unit + 1;
    endfunction

    task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] got);
        chk_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("FAIL %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        chk_cnt++;
        assert (cond) else begin
            err_cnt++;
            $display("ERROR: %s", msg);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk_i);
        #1;
    endtask

    // Exception values keep only the cause bits
    task automatic set_expected(input logic [ROB_IDX_LEN-1:0] idx, input logic exc);
        exp_except[idx]       = exc;
        exp_value[idx].result = lcg_next();
        if (exc) begin
            exp_value[idx].except.pad = '0;
        end
    endtask

    task automatic alloc_entries(input string name, input int n);
        for (int k = 0; k < n; k++) begin
            alloc_valid_i = 1'b1;
            @(negedge clk_i);
            check_true(alloc_ready_o, {name, ": allocation refused with free entries"});
            expect_eq({name, " alloc_idx_o"}, tail_model, alloc_idx_o);
            order_q.push_back(tail_model);
            tail_model = tail_model + 1'b1;
            @(posedge clk_i);
            #1;
        end
        alloc_valid_i = 1'b0;
    endtask

    // Holds valid until the result buffer takes it
    task automatic send_result(input int unit, input logic [ROB_IDX_LEN-1:0] idx);
        int waited;
        waited                        = 0;
        eu_valid_i[unit]              = 1'b1;
        eu_data_i[unit].rob_idx       = idx;
        eu_data_i[unit].value         = exp_value[idx];
        eu_data_i[unit].except_raised = exp_except[idx];
        @(negedge clk_i);
        while (!eu_ready_o[unit] && waited < MAX_WAIT) begin
            stall_cnt[unit]++;
            waited++;
            @(negedge clk_i);
        end
        check_true(eu_ready_o[unit], "result buffer never accepted a result");
        @(posedge clk_i);
        #1;
        eu_valid_i[unit] = 1'b0;
    endtask

    task automatic send_run(input int unit, input int first, input int last);
        for (int p = first; p <= last; p++) begin
            send_result(unit, order_q[p]);
        end
    endtask

    // Waits for n commits and compares them in allocation order
    task automatic check_commits(input string name, input int n);
        int                     waited;
        commit_data_t           got;
        logic [ROB_IDX_LEN-1:0] idx;
        waited = 0;
        while (commit_q.size() < n && waited < MAX_WAIT) begin
            @(posedge clk_i);
            #1;
            waited++;
        end
        check_true(commit_q.size() == n, {name, ": commit count differs from results sent"});
        for (int k = 0; k < n && commit_q.size() > 0; k++) begin
            got = commit_q.pop_front();
            idx = order_q.pop_front();
            expect_eq({name, " commit rob_idx"}, idx, got.rob_idx);
            expect_eq({name, " except_raised"}, exp_except[idx], got.except_raised);
            if (exp_except[idx]) begin
                expect_eq({name, " cause"}, exp_value[idx].except.cause, got.value.except.cause);
            end else begin
                expect_eq({name, " value"}, exp_value[idx].result, got.value.result);
            end
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk_i);
        check_true(alloc_ready_o, "alloc_ready_o low after reset");
        check_true(&eu_ready_o, "a result buffer is not ready after reset");
        check_true(!commit_valid_o && !cdb_valid_o, "valid output high after reset");
        expect_eq("reset alloc_idx_o", 0, alloc_idx_o);
        @(posedge clk_i);
        #1;
    endtask

    // --------------------------------------------------
    // Tests
    // --------------------------------------------------
    task automatic test_in_order();
        logic [ROB_IDX_LEN-1:0] idx [EU_N];
        commit_ready_i = 1'b1;
        alloc_entries("in_order", EU_N);
        for (int u = 0; u < EU_N; u++) begin
            idx[u] = order_q[u];
            set_expected(idx[u], 1'b0);
        end
        // Youngest entry first and each through its own unit
        for (int u = EU_N - 1; u >= 0; u--) begin
            send_result(u, idx[u]);
            if (u != 0) begin
                rr_model = next_rr(u);
            end
        end
        check_commits("in_order", EU_N);
    endtask

    task automatic test_arbitration();
        logic [ROB_IDX_LEN-1:0] idx [EU_N];
        int                     exp_unit [EU_N];
        cdb_data_t              got;
        bcast_q.delete();
        alloc_entries("arbitration", EU_N);
        for (int u = 0; u < EU_N; u++) begin
            idx[u] = order_q[u];
            set_expected(idx[u], 1'b0);
        end
        // Unit 0 first and the rest from the pointer on
        exp_unit[0] = 0;
        for (int k = 1; k < EU_N; k++) begin
            exp_unit[k] = (k == 1) ? rr_model : next_rr(exp_unit[k-1]);
        end
        rr_model = next_rr(exp_unit[EU_N-1]);
        fork
            send_result(0, idx[0]);
            send_result(1, idx[1]);
            send_result(2, idx[2]);
            send_result(3, idx[3]);
        join
        check_commits("arbitration", EU_N);
        check_true(bcast_q.size() == EU_N, "arbitration: wrong number of broadcasts");
        for (int k = 0; k < EU_N && bcast_q.size() > 0; k++) begin
            got = bcast_q.pop_front();
            expect_eq("arbitration order", idx[exp_unit[k]], got.rob_idx);
            expect_eq("arbitration value", exp_value[idx[exp_unit[k]]].result, got.value.result);
        end
    endtask

    task automatic test_exception();
        alloc_entries("exception", 1);
        set_expected(order_q[0], 1'b1);
        send_result(2, order_q[0]);
        rr_model = next_rr(2);
        check_commits("exception", 1);
    endtask

    task automatic test_back_pressure();
        commit_ready_i = 1'b0;
        stall_cnt[1]   = 0;
        alloc_entries("back_pressure", ROB_DEPTH);
        @(negedge clk_i);
        check_true(!alloc_ready_o, "back_pressure: alloc_ready_o high with the ROB full");
        @(posedge clk_i);
        #1;
        for (int p = 0; p < ROB_DEPTH; p++) begin
            set_expected(order_q[p], 1'b0);
        end
        // Unit 0 holds the bus while unit 1 fills up
        fork
            send_run(0, 3, ROB_DEPTH - 1);
            send_run(1, 0, 2);
        join
        rr_model = next_rr(1);
        idle(8);
        check_true(stall_cnt[1] > 0, "back_pressure: unit 1 never saw a full buffer");
        check_true(commit_valid_o, "back_pressure: head entry not offered for commit");
        expect_eq("back_pressure head rob_idx", order_q[0], commit_data_o.rob_idx);
        commit_ready_i = 1'b1;
        check_commits("back_pressure", ROB_DEPTH);
    endtask

    task automatic test_flush();
        commit_ready_i = 1'b0;
        bcast_q.delete();
        commit_q.delete();
        alloc_entries("flush", 2);
        set_expected(order_q[0], 1'b0);
        set_expected(order_q[1], 1'b0);
        fork
            send_result(2, order_q[0]);
            send_result(3, order_q[1]);
        join
        // Both results still waiting in their buffers
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i        = 1'b0;
        commit_ready_i = 1'b1;
        order_q.delete();
        tail_model = '0;
        rr_model   = 1;
        idle(10);
        check_true(commit_q.size() == 0, "flush: commit seen after flush");
        check_true(bcast_q.size() == 0, "flush: broadcast seen after flush");
        check_true(!commit_valid_o && !cdb_valid_o, "flush: valid output still high");
        expect_eq("flush alloc_idx_o", 0, alloc_idx_o);
    endtask

    // --------------------------------------------------
    // Sequence and verdict
    // --------------------------------------------------
    initial begin
        rst_n_i        = 1'b0;
        flush_i        = 1'b0;
        eu_valid_i     = '0;
        alloc_valid_i  = 1'b0;
        commit_ready_i = 1'b0;
        for (int u = 0; u < EU_N; u++) begin
            eu_data_i[u] = '0;
            stall_cnt[u] = 0;
        end
        lcg_state  = 32'd15;
        err_cnt    = 0;
        chk_cnt    = 0;
        tail_model = '0;
        rr_model   = 1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_reset_state();
        test_in_order();
        test_arbitration();
        test_exception();
        test_back_pressure();
        test_flush();
        idle(2);
        $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
